// ==== source/vt_pkg.sv ====
// ------------------------------------------------
// Shared types and default timing of the clock
// subsystem. All counts are in clk24 cycles
// ------------------------------------------------
`default_nettype none

package vt_pkg;

	// ------------------------------------------------
	// Bundles
	// ------------------------------------------------
	typedef struct packed {
		logic pipe_ab;     // Pipe A/B, 32 high / 32 low
		logic ce12;        // Pixel push @12 MHz
		logic ce6;         // Pixel push @6 MHz
		logic ce6x;        // Pre-pixel push @6 MHz
		logic ce3;         // CPU and pixel strobe @3 MHz
		logic video_slice; // Video owns the bus, 4 of 8
		logic ce1m5;       // Strobe @1.5 MHz
	} ce_bus_t;

	typedef struct packed {
		logic [9:0] hcount;  // Pixel count in ce12 steps
		logic [8:0] vcount;  // Line count
		logic       hsync;
		logic       vsync;
		logic       blank;
		logic       frame_start; // One-cycle pulse at 0,0
	} raster_t;

	// ------------------------------------------------
	// Defaults
	// ------------------------------------------------
	localparam int INIT_CYCLES_DEF = 3; // Start-up hold

	// Subcarrier NCO, 4 x 4.43361875 MHz at 24 MHz clock
	localparam int PHACC_W = 32;
	localparam logic [PHACC_W-1:0] PHACC_DELTA_DEF = 32'd3173707922;

	localparam int H_TOTAL_DEF      = 768; // ce12 steps per line
	localparam int H_SYNC_START_DEF = 640;
	localparam int H_SYNC_LEN_DEF   = 56;
	localparam int H_ACTIVE_DEF     = 512;

	localparam int V_TOTAL_DEF      = 312; // Lines per frame
	localparam int V_SYNC_START_DEF = 272;
	localparam int V_SYNC_LEN_DEF   = 4;
	localparam int V_ACTIVE_DEF     = 256;

endpackage

`default_nettype wire

// ==== source/timing_ctrl.sv ====
// ------------------------------------------------
// Start-up hold and resync sequencing
// INIT_CYCLES must be at least 1
// resync is ignored until run is up
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module timing_ctrl #(
	parameter int INIT_CYCLES = vt_pkg::INIT_CYCLES_DEF
) (
	input  wire  clk24,
	input  wire  arst_n,
	input  wire  resync, // One-cycle pulse
	output logic run,    // Datapaths enabled
	output logic clr     // Realign pulse, one cycle
);

	// Counter only needs to reach INIT_CYCLES-1
	localparam int HOLD_W = (INIT_CYCLES > 2) ? $clog2(INIT_CYCLES) : 1;
	localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(INIT_CYCLES - 1);

	logic [HOLD_W-1:0] hold_cnt;
	logic              hold_done;

	// Last hold cycle reached
	assign hold_done = (hold_cnt == HOLD_LAST);

	// ------------------------------------------------
	// Start-up hold
	// ------------------------------------------------
	// run rises on the INIT_CYCLES-th edge after release
	always_ff @(posedge clk24 or negedge arst_n) begin
		if (!arst_n) begin
			hold_cnt <= '0;
			run      <= 1'b0;
		end
		else if (!run) begin
			if (hold_done) begin
				run <= 1'b1; // latch, never drops again
			end
			else begin
				hold_cnt <= hold_cnt + 1'b1;
			end
		end
	end

	// ------------------------------------------------
	// Resync
	// ------------------------------------------------
	// Pulse is delayed one cycle so all datapaths
	// see the same clr edge
	always_ff @(posedge clk24 or negedge arst_n) begin
		if (!arst_n) begin
			clr <= 1'b0;
		end
		else begin
			clr <= resync & run; // run keeps going through it
		end
	end

endmodule

`default_nettype wire

// ==== source/ce_divider.sv ====
// ------------------------------------------------
// Clock enables from a 6-bit divider of clk24
// Every enable is one cycle behind its count
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ce_divider (
	input  wire             clk24,
	input  wire             arst_n,
	input  wire             run,
	input  wire             clr,
	output vt_pkg::ce_bus_t ce
);

	logic [5:0]      ctr;    // Free-running divider
	vt_pkg::ce_bus_t ce_nxt; // Decode of current count

	// ------------------------------------------------
	// Divider
	// ------------------------------------------------
	always_ff @(posedge clk24 or negedge arst_n) begin
		if (!arst_n) begin
			ctr <= '0;
		end
		else if (clr) begin
			ctr <= '0; // Decode sees zero next cycle
		end
		else if (run) begin
			ctr <= ctr + 1'b1;
		end
	end

	// ------------------------------------------------
	// Enable decode
	// ------------------------------------------------
	always_comb begin
		ce_nxt.pipe_ab     = ctr[5];               // 2x slower than 32
		ce_nxt.ce12        = ctr[0];               // Every second cycle
		ce_nxt.ce6         = ctr[1] & ctr[0];      // Pixel push
		ce_nxt.ce6x        = ctr[1] & ~ctr[0];     // Pre-pixel, one ahead
		ce_nxt.ce3         = ctr[2] & ctr[1] & ~ctr[0];
		ce_nxt.video_slice = ~ctr[2];              // Half of each 8
		// Same slot as ce3 in every other 8-cycle group
		ce_nxt.ce1m5       = ~ctr[3] & ctr[2] & ctr[1] & ~ctr[0];
	end

	// Registered so consumers see clean strobes
	always_ff @(posedge clk24 or negedge arst_n) begin
		if (!arst_n) begin
			ce <= '0;
		end
		else if (run) begin
			ce <= ce_nxt; // Uses the count before the increment
		end
	end

endmodule

`default_nettype wire

// ==== source/pal_nco.sv ====
// ------------------------------------------------
// PAL subcarrier phase accumulator at clk24
// fsc is 4x Fsc as a square wave, with jitter
// of one clk24 period
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pal_nco #(
	parameter logic [vt_pkg::PHACC_W-1:0] PHACC_DELTA = vt_pkg::PHACC_DELTA_DEF
) (
	input  wire                        clk24,
	input  wire                        arst_n,
	input  wire                        run,
	input  wire                        clr,
	output logic [vt_pkg::PHACC_W-1:0] phase, // For a later sine lookup
	output logic                       fsc
);

	logic [vt_pkg::PHACC_W-1:0] phase_nxt;

	// Wraps modulo 2^PHACC_W, overflow rate sets Fsc
	assign phase_nxt = phase + PHACC_DELTA;

	// ------------------------------------------------
	// Accumulator
	// ------------------------------------------------
	always_ff @(posedge clk24 or negedge arst_n) begin
		if (!arst_n) begin
			phase <= '0;
		end
		else if (clr) begin
			phase <= '0; // Resync restarts at phase zero
		end
		else if (run) begin
			phase <= phase_nxt;
		end
	end

	// Top bit is the square wave
	assign fsc = phase[vt_pkg::PHACC_W-1];

endmodule

`default_nettype wire

// ==== source/raster_timer.sv ====
// ------------------------------------------------
// Line and frame counters stepped by ce12
// Sync windows must not cross the wrap point
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module raster_timer #(
	parameter int H_TOTAL      = vt_pkg::H_TOTAL_DEF,
	parameter int H_SYNC_START = vt_pkg::H_SYNC_START_DEF,
	parameter int H_SYNC_LEN   = vt_pkg::H_SYNC_LEN_DEF,
	parameter int H_ACTIVE     = vt_pkg::H_ACTIVE_DEF,
	parameter int V_TOTAL      = vt_pkg::V_TOTAL_DEF,
	parameter int V_SYNC_START = vt_pkg::V_SYNC_START_DEF,
	parameter int V_SYNC_LEN   = vt_pkg::V_SYNC_LEN_DEF,
	parameter int V_ACTIVE     = vt_pkg::V_ACTIVE_DEF
) (
	input  wire                  clk24,
	input  wire                  arst_n,
	input  wire                  run,
	input  wire                  clr,
	input  wire vt_pkg::ce_bus_t ce,
	output vt_pkg::raster_t      raster
);

	// Window edges at counter width
	localparam logic [9:0] H_LAST  = 10'(H_TOTAL - 1);
	localparam logic [9:0] HS_BEG  = 10'(H_SYNC_START);
	localparam logic [9:0] HS_END  = 10'(H_SYNC_START + H_SYNC_LEN);
	localparam logic [9:0] H_ACT   = 10'(H_ACTIVE);
	localparam logic [8:0] V_LAST  = 9'(V_TOTAL - 1);
	localparam logic [8:0] VS_BEG  = 9'(V_SYNC_START);
	localparam logic [8:0] VS_END  = 9'(V_SYNC_START + V_SYNC_LEN);
	localparam logic [8:0] V_ACT   = 9'(V_ACTIVE);

	logic       step;   // One pixel step
	logic       h_wrap; // End of line
	logic       v_wrap; // Last line of frame
	logic [9:0] h_nxt;
	logic [8:0] v_nxt;

	// ------------------------------------------------
	// Next counts
	// ------------------------------------------------
	assign step   = run & ce.ce12;
	assign h_wrap = (raster.hcount == H_LAST);
	assign v_wrap = (raster.vcount == V_LAST);

	always_comb begin
		h_nxt = h_wrap ? 10'd0 : raster.hcount + 1'b1;
		v_nxt = raster.vcount;
		if (h_wrap) begin
			v_nxt = v_wrap ? 9'd0 : raster.vcount + 1'b1; // New line
		end
	end

	// ------------------------------------------------
	// Counters and flags
	// ------------------------------------------------
	// Flags come from the new counts, so they line up
	// with hcount/vcount in the same cycle
	always_ff @(posedge clk24 or negedge arst_n) begin
		if (!arst_n) begin
			raster <= '0;
		end
		else if (clr) begin
			raster <= '0; // Zero counts sit in active area, no strobe
		end
		else begin
			raster.frame_start <= 1'b0; // Pulse by default
			if (step) begin
				raster.hcount      <= h_nxt;
				raster.vcount      <= v_nxt;
				raster.hsync       <= (h_nxt >= HS_BEG) && (h_nxt < HS_END);
				raster.vsync       <= (v_nxt >= VS_BEG) && (v_nxt < VS_END);
				raster.blank       <= (h_nxt >= H_ACT) || (v_nxt >= V_ACT);
				raster.frame_start <= h_wrap & v_wrap; // Both back to 0
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/video_timing_top.sv ====
// ------------------------------------------------
// Clock and raster timing top, all on clk24
// resync is a single-cycle pulse
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module video_timing_top #(
	parameter int INIT_CYCLES = vt_pkg::INIT_CYCLES_DEF,
	parameter logic [vt_pkg::PHACC_W-1:0] PHACC_DELTA = vt_pkg::PHACC_DELTA_DEF,
	parameter int H_TOTAL      = vt_pkg::H_TOTAL_DEF,
	parameter int H_SYNC_START = vt_pkg::H_SYNC_START_DEF,
	parameter int H_SYNC_LEN   = vt_pkg::H_SYNC_LEN_DEF,
	parameter int H_ACTIVE     = vt_pkg::H_ACTIVE_DEF,
	parameter int V_TOTAL      = vt_pkg::V_TOTAL_DEF,
	parameter int V_SYNC_START = vt_pkg::V_SYNC_START_DEF,
	parameter int V_SYNC_LEN   = vt_pkg::V_SYNC_LEN_DEF,
	parameter int V_ACTIVE     = vt_pkg::V_ACTIVE_DEF
) (
	input  wire                        clk24,
	input  wire                        arst_n,
	input  wire                        resync,
	output vt_pkg::ce_bus_t            ce,
	output vt_pkg::raster_t            raster,
	output logic [vt_pkg::PHACC_W-1:0] phase,
	output logic                       fsc
);

	logic run; // Shared enable, up after the hold
	logic clr; // Shared realign pulse

	// ------------------------------------------------
	// Sequencing
	// ------------------------------------------------
	timing_ctrl #(
		.INIT_CYCLES (INIT_CYCLES)
	) u_ctrl (
		.clk24  (clk24),
		.arst_n (arst_n),
		.resync (resync),
		.run    (run),
		.clr    (clr)
	);

	// ------------------------------------------------
	// Datapaths
	// ------------------------------------------------
	ce_divider u_div (
		.clk24  (clk24),
		.arst_n (arst_n),
		.run    (run),
		.clr    (clr),
		.ce     (ce)
	);

	pal_nco #(
		.PHACC_DELTA (PHACC_DELTA)
	) u_nco (
		.clk24  (clk24),
		.arst_n (arst_n),
		.run    (run),
		.clr    (clr),
		.phase  (phase),
		.fsc    (fsc)
	);

	raster_timer #(
		.H_TOTAL      (H_TOTAL),
		.H_SYNC_START (H_SYNC_START),
		.H_SYNC_LEN   (H_SYNC_LEN),
		.H_ACTIVE     (H_ACTIVE),
		.V_TOTAL      (V_TOTAL),
		.V_SYNC_START (V_SYNC_START),
		.V_SYNC_LEN   (V_SYNC_LEN),
		.V_ACTIVE     (V_ACTIVE)
	) u_raster (
		.clk24  (clk24),
		.arst_n (arst_n),
		.run    (run),
		.clr    (clr),
		.ce     (ce),     // Steps on ce12
		.raster (raster)
	);

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
// ------------------------------------------------
// Testbench clock and reset, reset is dropped at
// 1 ns and released on a falling edge
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 5
) (
	output logic clk24,
	output logic arst_n
);

	// Free-running clock, starts low
	initial begin
		clk24 = 1'b0;
		forever #(PERIOD_NS / 2) clk24 = ~clk24;
	end

	initial begin
		arst_n = 1'b1;
		#1;
		arst_n = 1'b0; // Clean falling edge for the async reset
		repeat (RESET_CYCLES) @(posedge clk24);
		@(negedge clk24);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== sim/video_timing_sva.sv ====
// ------------------------------------------------
// Enable periodicity and raster flag checks
// Periods are checked only once run is settled
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module video_timing_sva (
	input wire                  clk24,
	input wire                  arst_n,
	input wire                  run,
	input wire                  clr,
	input wire vt_pkg::ce_bus_t ce,
	input wire vt_pkg::raster_t raster
);

	localparam logic [9:0] HS_BEG = 10'(vt_pkg::H_SYNC_START_DEF);
	localparam logic [9:0] HS_END = 10'(vt_pkg::H_SYNC_START_DEF + vt_pkg::H_SYNC_LEN_DEF);
	localparam logic [9:0] H_ACT  = 10'(vt_pkg::H_ACTIVE_DEF);
	localparam logic [8:0] VS_BEG = 9'(vt_pkg::V_SYNC_START_DEF);
	localparam logic [8:0] VS_END = 9'(vt_pkg::V_SYNC_START_DEF + vt_pkg::V_SYNC_LEN_DEF);
	localparam logic [8:0] V_ACT  = 9'(vt_pkg::V_ACTIVE_DEF);

	int unsigned fail_count = 0; // Failure tally
	logic [6:0]  settled;        // Cycles since run rose or clr

	// Saturating age of the divider sequence
	always_ff @(posedge clk24 or negedge arst_n) begin
		if (!arst_n) begin
			settled <= '0;
		end
		else if (!run || clr) begin
			settled <= '0; // Sequence restarts here
		end
		else if (settled != 7'h7f) begin
			settled <= settled + 1'b1;
		end
	end

	// ------------------------------------------------
	// Enable periodicity
	// ------------------------------------------------
	a_ce12_toggle: assert property (@(posedge clk24) disable iff (!arst_n)
		settled >= 7'd2 |-> ce.ce12 != $past(ce.ce12))
		else begin fail_count++; $error("ce12 did not alternate"); end

	a_ce3_period: assert property (@(posedge clk24) disable iff (!arst_n)
		settled >= 7'd9 |-> ce.ce3 == $past(ce.ce3, 8))
		else begin fail_count++; $error("ce3 broke its 8-cycle period"); end

	a_ce1m5_period: assert property (@(posedge clk24) disable iff (!arst_n)
		settled >= 7'd17 |-> ce.ce1m5 == $past(ce.ce1m5, 16))
		else begin fail_count++; $error("ce1m5 broke its 16-cycle period"); end

	a_ce1m5_in_ce3: assert property (@(posedge clk24) disable iff (!arst_n)
		ce.ce1m5 |-> ce.ce3) // Same slot, every other group
		else begin fail_count++; $error("ce1m5 outside a ce3 slot"); end

	a_pipe_ab_half: assert property (@(posedge clk24) disable iff (!arst_n)
		settled >= 7'd33 |-> ce.pipe_ab != $past(ce.pipe_ab, 32))
		else begin fail_count++; $error("pipe_ab did not flip after 32 cycles"); end

	// ------------------------------------------------
	// Raster flags
	// ------------------------------------------------
	a_frame_zero: assert property (@(posedge clk24) disable iff (!arst_n)
		raster.frame_start |-> (raster.hcount == '0) && (raster.vcount == '0))
		else begin fail_count++; $error("frame_start away from count zero"); end

	a_hsync_win: assert property (@(posedge clk24) disable iff (!arst_n)
		raster.hsync == ((raster.hcount >= HS_BEG) && (raster.hcount < HS_END)))
		else begin fail_count++; $error("hsync outside its window"); end

	a_vsync_win: assert property (@(posedge clk24) disable iff (!arst_n)
		raster.vsync == ((raster.vcount >= VS_BEG) && (raster.vcount < VS_END)))
		else begin fail_count++; $error("vsync outside its window"); end

	a_blank_win: assert property (@(posedge clk24) disable iff (!arst_n)
		raster.blank == ((raster.hcount >= H_ACT) || (raster.vcount >= V_ACT)))
		else begin fail_count++; $error("blank disagrees with the active area"); end

endmodule

`default_nettype wire

// ==== sim/tb_video_timing.sv ====
// ------------------------------------------------
// Testbench for video_timing_top, default params
// Runs two full frames with random resync pulses
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_video_timing;

	localparam int     PERIOD_NS  = 40;
	localparam int     N_RESYNC   = 3;    // Pulses between the two frames
	localparam int     GAP_MAX    = 4000; // Max cycles before each pulse
	localparam longint RUN_CYCLES = 2 * vt_pkg::H_TOTAL_DEF * vt_pkg::V_TOTAL_DEF * 2;
	localparam longint WATCHDOG_NS = RUN_CYCLES * PERIOD_NS * 11 / 10; // +10%

	wire                          clk24;
	wire                          arst_n;
	logic                         resync;
	vt_pkg::ce_bus_t              ce;
	vt_pkg::raster_t              raster;
	logic [vt_pkg::PHACC_W-1:0]   phase;
	logic                         fsc;

	// Reference state
	int unsigned     m_edges; // Edges since reset release
	logic            m_run;
	logic            m_clr;
	logic [5:0]      m_ctr;
	vt_pkg::ce_bus_t m_ce;
	logic [31:0]     m_steps; // Run cycles since reset or clr
	logic [9:0]      m_h;
	logic [8:0]      m_v;
	logic            m_fs;

	tb_clk_gen #(
		.PERIOD_NS    (PERIOD_NS),
		.RESET_CYCLES (5)
	) u_clk (
		.clk24  (clk24),
		.arst_n (arst_n)
	);

	video_timing_top i_dut (
		.clk24  (clk24),
		.arst_n (arst_n),
		.resync (resync),
		.ce     (ce),
		.raster (raster),
		.phase  (phase),
		.fsc    (fsc)
	);

	bind video_timing_top video_timing_sva u_sva (
		.clk24  (clk24),
		.arst_n (arst_n),
		.run    (run),
		.clr    (clr),
		.ce     (ce),
		.raster (raster)
	);

	// ------------------------------------------------
	// Helpers
	// ------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp)
		else abort_run($sformatf("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act));
	endtask

	// Enable rules on one divider count
	function automatic vt_pkg::ce_bus_t enables_for_count(input logic [5:0] c);
		vt_pkg::ce_bus_t e;
		e.ce12        = c[0];
		e.ce6         = (c[1:0] == 2'b11);
		e.ce6x        = (c[1:0] == 2'b10);
		e.ce3         = (c[2:0] == 3'b110);
		e.video_slice = !c[2];
		e.ce1m5       = (c[3:0] == 4'b0110);
		e.pipe_ab     = c[5];
		return e;
	endfunction

	function automatic logic [31:0] phase_after(input logic [31:0] n);
		logic [63:0] prod;
		prod = 64'(n) * 64'(vt_pkg::PHACC_DELTA_DEF); // Modulo 2^32 below
		return prod[31:0];
	endfunction

	function automatic logic in_window(input int pos, input int start, input int len);
		return (pos >= start) && (pos < start + len);
	endfunction

	task automatic wait_frames(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(negedge clk24);
			if (raster.frame_start) begin
				seen++;
			end
		end
	endtask

	// ------------------------------------------------
	// Reference models
	// ------------------------------------------------
	always @(posedge clk24 or negedge arst_n) begin
		if (!arst_n) begin
			m_edges <= 0;
			m_run   <= 1'b0;
			m_clr   <= 1'b0;
			m_ctr   <= '0;
			m_ce    <= '0;
			m_steps <= '0;
			m_h     <= '0;
			m_v     <= '0;
			m_fs    <= 1'b0;
		end
		else begin
			if (!m_run) begin
				m_edges <= m_edges + 1;
				if (m_edges + 1 == vt_pkg::INIT_CYCLES_DEF) m_run <= 1'b1;
			end
			m_clr <= resync & m_run; // Clear one cycle after the pulse
			if (m_clr) begin
				m_ctr   <= '0;
				m_steps <= '0;
			end
			else if (m_run) begin
				m_ctr   <= m_ctr + 1'b1;
				m_steps <= m_steps + 1'b1;
			end
			if (m_run) m_ce <= enables_for_count(m_ctr); // Previous count
			m_fs <= 1'b0;
			if (m_clr) begin
				m_h <= '0;
				m_v <= '0;
			end
			else if (m_run && m_ce.ce12) begin
				if (m_h == vt_pkg::H_TOTAL_DEF - 1) begin
					m_h <= '0;
					if (m_v == vt_pkg::V_TOTAL_DEF - 1) begin
						m_v  <= '0;
						m_fs <= 1'b1; // Both wrap together
					end
					else begin
						m_v <= m_v + 1'b1;
					end
				end
				else begin
					m_h <= m_h + 1'b1;
				end
			end
		end
	end

	// ------------------------------------------------
	// Checks, on falling edges where outputs are stable
	// ------------------------------------------------
	always @(negedge clk24) begin : check_outputs
		logic [31:0] exp_phase;
		exp_phase = phase_after(m_steps);
		if (!m_run) check_eq("ce", '0, ce); // Idle through start-up
		check_eq("ce.pipe_ab", m_ce.pipe_ab, ce.pipe_ab);
		check_eq("ce.ce12", m_ce.ce12, ce.ce12);
		check_eq("ce.ce6", m_ce.ce6, ce.ce6);
		check_eq("ce.ce6x", m_ce.ce6x, ce.ce6x);
		check_eq("ce.ce3", m_ce.ce3, ce.ce3);
		check_eq("ce.video_slice", m_ce.video_slice, ce.video_slice);
		check_eq("ce.ce1m5", m_ce.ce1m5, ce.ce1m5);
		check_eq("phase", exp_phase, phase);
		check_eq("fsc", exp_phase[31], fsc);
		check_eq("raster.hcount", m_h, raster.hcount);
		check_eq("raster.vcount", m_v, raster.vcount);
		check_eq("raster.hsync",
			in_window(m_h, vt_pkg::H_SYNC_START_DEF, vt_pkg::H_SYNC_LEN_DEF), raster.hsync);
		check_eq("raster.vsync",
			in_window(m_v, vt_pkg::V_SYNC_START_DEF, vt_pkg::V_SYNC_LEN_DEF), raster.vsync);
		check_eq("raster.blank",
			(m_h >= vt_pkg::H_ACTIVE_DEF) || (m_v >= vt_pkg::V_ACTIVE_DEF), raster.blank);
		check_eq("raster.frame_start", m_fs, raster.frame_start);
		if (i_dut.u_sva.fail_count != 0) begin
			abort_run("A concurrent assertion on the timing outputs failed");
		end
	end

	// ------------------------------------------------
	// Stimulus
	// ------------------------------------------------
	initial begin : stimulus
		int unsigned gap;
		resync = 1'b0;
		void'($urandom(32'hee6c)); // Single seed for the run
		wait (arst_n === 1'b0);
		wait (arst_n === 1'b1);
		wait_frames(1); // Full frame from start-up
		repeat (N_RESYNC) begin
			gap = $urandom_range(GAP_MAX, 1);
			repeat (gap) @(negedge clk24);
			resync = 1'b1;
			@(negedge clk24);
			resync = 1'b0;
		end
		wait_frames(1); // Full frame after the last realign
		repeat (4) @(negedge clk24);
		if (i_dut.u_sva.fail_count != 0) begin
			abort_run("A concurrent assertion on the timing outputs failed");
		end
		else begin
			$display("All checks passed");
			$finish;
		end
	end

	// Two frames plus margin
	initial begin : watchdog
		#(WATCHDOG_NS);
		abort_run("Timeout, the run hung before both frames completed");
	end

endmodule

`default_nettype wire

// ==== tb.f ====
source/vt_pkg.sv
source/timing_ctrl.sv
source/ce_divider.sv
source/pal_nco.sv
source/raster_timer.sv
source/video_timing_top.sv
sim/tb_clk_gen.sv
sim/video_timing_sva.sv
sim/tb_video_timing.sv
